/* axil_bram.sv */
// ==========================================================================
// AXI-Lite slave RAM with byte strobes. Word indices at or past the RAM
// depth leave memory alone and answer SLVERR, with zero data on reads.
// ==========================================================================
`timescale 1ns/1ps

module axil_bram (
    input  logic                       aclk,
    input  logic                       rst_n,
    input  logic [lsu_pkg::ADDR_W-1:0] awaddr,
    input  logic                       awvalid,
    output logic                       awready,
    input  logic [lsu_pkg::DATA_W-1:0] wdata,
    input  logic [3:0]                 wstrb,
    input  logic                       wvalid,
    output logic                       wready,
    output logic [1:0]                 bresp,
    output logic                       bvalid,
    input  logic                       bready,
    input  logic [lsu_pkg::ADDR_W-1:0] araddr,
    input  logic                       arvalid,
    output logic                       arready,
    output logic [lsu_pkg::DATA_W-1:0] rdata,
    output logic [1:0]                 rresp,
    output logic                       rvalid,
    input  logic                       rready
);
    logic [lsu_pkg::DATA_W-1:0] mem [lsu_pkg::MEM_WORDS];
    logic [lsu_pkg::ADDR_W-1:0] waddr_q;
    logic                       aw_held;
    logic                       w_fire;
    logic                       ar_fire;
    logic                       w_in_range;
    logic                       r_in_range;

    assign w_fire  = wvalid && wready;
    assign ar_fire = arvalid && arready;

    // Range check on the word index
    assign w_in_range = waddr_q[lsu_pkg::ADDR_W-1:2] < (lsu_pkg::ADDR_W-2)'(lsu_pkg::MEM_WORDS);
    assign r_in_range = araddr[lsu_pkg::ADDR_W-1:2] < (lsu_pkg::ADDR_W-2)'(lsu_pkg::MEM_WORDS);

    // ======================================================================
    // Handshake control
    // ======================================================================
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            arready <= 1'b0;
            rvalid  <= 1'b0;
            aw_held <= 1'b0;
        end else begin
            // Ready pulses one cycle after valid
            awready <= awvalid && !awready && !aw_held;
            wready  <= wvalid && !wready && aw_held && !bvalid;
            arready <= arvalid && !arready && !rvalid;
            if (awvalid && awready) aw_held <= 1'b1;
            else if (w_fire)        aw_held <= 1'b0;
            if (w_fire)                  bvalid <= 1'b1;
            else if (bvalid && bready)   bvalid <= 1'b0;
            if (ar_fire)                 rvalid <= 1'b1;
            else if (rvalid && rready)   rvalid <= 1'b0;
        end
    end

    // Address, response payload and memory array
    always_ff @(posedge aclk) begin
        if (awvalid && awready) waddr_q <= awaddr;
        if (w_fire) begin
            bresp <= w_in_range ? lsu_pkg::RESP_OKAY : lsu_pkg::RESP_SLVERR;
            for (int i = 0; i < 4; i++) begin
                if (w_in_range && wstrb[i]) begin
                    mem[waddr_q[lsu_pkg::MEM_IDX_W+1:2]][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
        if (ar_fire) begin
            rdata <= r_in_range ? mem[araddr[lsu_pkg::MEM_IDX_W+1:2]] : '0;
            rresp <= r_in_range ? lsu_pkg::RESP_OKAY : lsu_pkg::RESP_SLVERR;
        end
    end

endmodule

/* build.f */
lsu_pkg.sv
lsu_decode.sv
lsu_axil_master.sv
lsu_load_align.sv
axil_bram.sv
lsu_subsystem.sv
lsu_checker.sv
tb_lsu_subsystem.sv

/* lsu_axil_master.sv */
// ==========================================================================
// Execute stage: AXI-Lite master FSM running one read or write per decoded
// request. Misaligned requests complete with an error and never hit the bus.
// ==========================================================================
`timescale 1ns/1ps

module lsu_axil_master (
    input  logic                       aclk,
    input  logic                       rst_n,
    // Decoded request
    input  logic                       dec_valid,
    input  logic                       dec_write,
    input  logic [lsu_pkg::ADDR_W-1:0] dec_addr,
    input  logic [lsu_pkg::DATA_W-1:0] dec_wdata,
    input  logic [3:0]                 dec_strb,
    input  logic                       dec_misaligned,
    // Completion towards the result stage
    output logic                       exe_done,
    output logic [lsu_pkg::DATA_W-1:0] exe_rdata,
    output logic                       exe_err,
    output logic                       exe_write,
    // AXI-Lite master
    output logic [lsu_pkg::ADDR_W-1:0] awaddr,
    output logic                       awvalid,
    input  logic                       awready,
    output logic [lsu_pkg::DATA_W-1:0] wdata,
    output logic [3:0]                 wstrb,
    output logic                       wvalid,
    input  logic                       wready,
    input  logic [1:0]                 bresp,
    input  logic                       bvalid,
    output logic                       bready,
    output logic [lsu_pkg::ADDR_W-1:0] araddr,
    output logic                       arvalid,
    input  logic                       arready,
    input  logic [lsu_pkg::DATA_W-1:0] rdata,
    input  logic [1:0]                 rresp,
    input  logic                       rvalid,
    output logic                       rready
);
    lsu_pkg::lsu_state_t state;
    lsu_pkg::lsu_state_t next_state;

    logic skip_c;
    logic wr_fin_c;
    logic rd_fin_c;

    // ======================================================================
    // FSM
    // ======================================================================
    always_comb begin
        next_state = state;
        case (state)
            lsu_pkg::ST_IDLE: begin
                // Misaligned requests stay here and finish next cycle
                if (dec_valid && !dec_misaligned) begin
                    next_state = dec_write ? lsu_pkg::ST_WRITE_ADDR : lsu_pkg::ST_READ_ADDR;
                end
            end
            lsu_pkg::ST_WRITE_ADDR: begin
                if (awready) next_state = lsu_pkg::ST_WRITE_DATA;
            end
            lsu_pkg::ST_WRITE_DATA: begin
                if (wready) next_state = lsu_pkg::ST_WRITE_RESP;
            end
            lsu_pkg::ST_WRITE_RESP: begin
                if (bvalid) next_state = lsu_pkg::ST_IDLE;
            end
            lsu_pkg::ST_READ_ADDR: begin
                if (arready) next_state = lsu_pkg::ST_READ_DATA;
            end
            lsu_pkg::ST_READ_DATA: begin
                if (rvalid) next_state = lsu_pkg::ST_IDLE;
            end
            default: next_state = lsu_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            state    <= lsu_pkg::ST_IDLE;
            exe_done <= 1'b0;
        end else begin
            state    <= next_state;
            exe_done <= skip_c | wr_fin_c | rd_fin_c;
        end
    end

    // Channel controls straight from the state, one phase at a time
    assign awvalid = (state == lsu_pkg::ST_WRITE_ADDR);
    assign wvalid  = (state == lsu_pkg::ST_WRITE_DATA);
    assign bready  = (state == lsu_pkg::ST_WRITE_RESP);
    assign arvalid = (state == lsu_pkg::ST_READ_ADDR);
    assign rready  = (state == lsu_pkg::ST_READ_DATA);

    // Decode holds its payload for the whole transaction
    assign awaddr = dec_addr;
    assign araddr = dec_addr;
    assign wdata  = dec_wdata;
    assign wstrb  = dec_strb;

    // ======================================================================
    // Completion
    // ======================================================================
    assign skip_c   = (state == lsu_pkg::ST_IDLE) && dec_valid && dec_misaligned;
    assign wr_fin_c = bvalid && bready;
    assign rd_fin_c = rvalid && rready;

    // Error responses complete like any other, flagged through exe_err
    always_ff @(posedge aclk) begin
        if (skip_c) begin
            exe_rdata <= '0;
            exe_err   <= 1'b1;
            exe_write <= dec_write;
        end else if (wr_fin_c) begin
            exe_rdata <= '0;
            exe_err   <= (bresp != lsu_pkg::RESP_OKAY);
            exe_write <= 1'b1;
        end else if (rd_fin_c) begin
            exe_rdata <= rdata;
            exe_err   <= (rresp != lsu_pkg::RESP_OKAY);
            exe_write <= 1'b0;
        end
    end

endmodule

/* lsu_checker.sv */
// ==========================================================================
// Concurrent protocol checks on the AXI-Lite master of the load/store path.
// Bound into every lsu_axil_master instance and disabled during reset.
// ==========================================================================
`timescale 1ns/1ps

module lsu_checker (
    input  logic                       aclk,
    input  logic                       rst_n,
    input  logic                       dec_valid,
    input  logic [lsu_pkg::ADDR_W-1:0] awaddr,
    input  logic                       awvalid,
    input  logic                       awready,
    input  logic [lsu_pkg::DATA_W-1:0] wdata,
    input  logic [3:0]                 wstrb,
    input  logic                       wvalid,
    input  logic                       wready,
    input  logic [lsu_pkg::ADDR_W-1:0] araddr,
    input  logic                       arvalid,
    input  logic                       arready,
    input  lsu_pkg::lsu_state_t        state
);
    // Valid and its payload hold until ready arrives
    aw_hold: assert property (@(posedge aclk) disable iff (!rst_n)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else $error("awvalid or awaddr changed before awready");

    w_hold: assert property (@(posedge aclk) disable iff (!rst_n)
        wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
        else $error("wvalid, wdata or wstrb changed before wready");

    ar_hold: assert property (@(posedge aclk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else $error("arvalid or araddr changed before arready");

    // Only one address channel active at a time
    aw_ar_excl: assert property (@(posedge aclk) disable iff (!rst_n)
        !(awvalid && arvalid))
        else $error("awvalid and arvalid high together");

    // Decode only fires into an idle FSM with one request outstanding
    dec_in_idle: assert property (@(posedge aclk) disable iff (!rst_n)
        dec_valid |-> state == lsu_pkg::ST_IDLE)
        else $error("dec_valid while the master FSM is not idle");

endmodule

bind lsu_axil_master lsu_checker u_checker (
    .aclk(aclk), .rst_n(rst_n), .dec_valid(dec_valid),
    .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
    .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
    .araddr(araddr), .arvalid(arvalid), .arready(arready), .state(state)
);

/* lsu_decode.sv */
// ==========================================================================
// Decode stage: captures a request strobe, forms byte strobes, lane data
// and the misaligned flag, and tracks busy until the response goes out.
// ==========================================================================
`timescale 1ns/1ps

module lsu_decode (
    input  logic                       aclk,
    input  logic                       rst_n,
    input  logic                       req_valid,
    input  logic                       req_write,
    input  lsu_pkg::mem_size_t         req_size,
    input  logic                       req_unsigned,
    input  logic [lsu_pkg::ADDR_W-1:0] req_addr,
    input  logic [lsu_pkg::DATA_W-1:0] req_wdata,
    input  logic                       rsp_valid,
    output logic                       dec_valid,
    output logic                       dec_write,
    output logic [lsu_pkg::ADDR_W-1:0] dec_addr,
    output logic [lsu_pkg::DATA_W-1:0] dec_wdata,
    output logic [3:0]                 dec_strb,
    output logic                       dec_misaligned,
    output logic [1:0]                 dec_offset,
    output lsu_pkg::mem_size_t         dec_size,
    output logic                       dec_unsigned,
    output logic                       busy
);
    logic [3:0]                 strb_c;
    logic [lsu_pkg::DATA_W-1:0] wdata_c;
    logic                       misaligned_c;
    logic                       busy_q;

    // Lane placement, store data replicated so the strobe picks the lane
    always_comb begin
        case (req_size)
            lsu_pkg::SIZE_BYTE: begin
                strb_c       = 4'b0001 << req_addr[1:0];
                wdata_c      = {4{req_wdata[7:0]}};
                misaligned_c = 1'b0;
            end
            lsu_pkg::SIZE_HALF: begin
                strb_c       = 4'b0011 << req_addr[1:0];
                wdata_c      = {2{req_wdata[15:0]}};
                misaligned_c = req_addr[0];
            end
            default: begin
                strb_c       = 4'b1111;
                wdata_c      = req_wdata;
                misaligned_c = |req_addr[1:0];
            end
        endcase
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
            busy_q    <= 1'b0;
        end else begin
            dec_valid <= req_valid;
            // A new strobe wins over the clear of the previous one
            if (req_valid) begin
                busy_q <= 1'b1;
            end else if (rsp_valid) begin
                busy_q <= 1'b0;
            end
        end
    end

    // Held until the next strobe, the result stage still needs offset/size
    always_ff @(posedge aclk) begin
        if (req_valid) begin
            dec_write      <= req_write;
            dec_addr       <= {req_addr[lsu_pkg::ADDR_W-1:2], 2'b00};
            dec_wdata      <= wdata_c;
            dec_strb       <= strb_c;
            dec_misaligned <= misaligned_c;
            dec_offset     <= req_addr[1:0];
            dec_size       <= req_size;
            dec_unsigned   <= req_unsigned;
        end
    end

    // Drops together with the response strobe
    assign busy = busy_q & ~rsp_valid;

endmodule

/* lsu_load_align.sv */
// ==========================================================================
// Result stage: pulls the addressed byte or halfword out of the raw word,
// extends it, and registers the single-cycle response strobe.
// ==========================================================================
`timescale 1ns/1ps

module lsu_load_align (
    input  logic                       aclk,
    input  logic                       rst_n,
    input  logic                       exe_done,
    input  logic [lsu_pkg::DATA_W-1:0] exe_rdata,
    input  logic                       exe_err,
    input  logic                       exe_write,
    input  logic [1:0]                 dec_offset,
    input  lsu_pkg::mem_size_t         dec_size,
    input  logic                       dec_unsigned,
    output logic                       rsp_valid,
    output logic [lsu_pkg::DATA_W-1:0] rsp_rdata,
    output logic                       rsp_err
);
    logic [lsu_pkg::DATA_W-1:0] shifted_c;
    logic [lsu_pkg::DATA_W-1:0] load_c;

    // Addressed lane moved down to bit 0
    assign shifted_c = exe_rdata >> {dec_offset, 3'b000};

    always_comb begin
        case (dec_size)
            lsu_pkg::SIZE_BYTE:
                load_c = {{(lsu_pkg::DATA_W-8){~dec_unsigned & shifted_c[7]}},
                          shifted_c[7:0]};
            lsu_pkg::SIZE_HALF:
                load_c = {{(lsu_pkg::DATA_W-16){~dec_unsigned & shifted_c[15]}},
                          shifted_c[15:0]};
            default:
                load_c = exe_rdata;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            rsp_valid <= 1'b0;
        end else begin
            rsp_valid <= exe_done;
        end
    end

    // Writes and failed accesses return zero data
    always_ff @(posedge aclk) begin
        if (exe_done) begin
            rsp_rdata <= (exe_write || exe_err) ? '0 : load_c;
            rsp_err   <= exe_err;
        end
    end

endmodule

/* lsu_pkg.sv */
// ==========================================================================
// Shared definitions for the uncached load/store path and its AXI-Lite RAM.
// Referenced by scoped name from every RTL file and from the testbench.
// ==========================================================================

package lsu_pkg;

    // Bus widths
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // RAM depth in 32-bit words, anything at or past it is out of range
    localparam int MEM_WORDS = 256;
    // Word index width into the RAM array
    localparam int MEM_IDX_W = $clog2(MEM_WORDS);

    // Access size of a CPU request
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_t;

    // AXI response codes actually produced by the RAM
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // ======================================================================
    // Execute stage FSM
    // ======================================================================
    typedef enum logic [2:0] {
        ST_IDLE       = 3'd0,
        ST_WRITE_ADDR = 3'd1,
        ST_WRITE_DATA = 3'd2,
        ST_WRITE_RESP = 3'd3,
        ST_READ_ADDR  = 3'd4,
        ST_READ_DATA  = 3'd5
    } lsu_state_t;

endpackage

/* lsu_subsystem.sv */
// ==========================================================================
// Load/store subsystem top: decode, AXI-Lite master, result stage and the
// RAM behind it. Accepts one request at a time while busy is low.
// ==========================================================================
`timescale 1ns/1ps

module lsu_subsystem (
    input  logic                       aclk,
    input  logic                       rst_n,
    input  logic                       req_valid,
    input  logic                       req_write,
    input  lsu_pkg::mem_size_t         req_size,
    input  logic                       req_unsigned,
    input  logic [lsu_pkg::ADDR_W-1:0] req_addr,
    input  logic [lsu_pkg::DATA_W-1:0] req_wdata,
    output logic                       busy,
    output logic                       rsp_valid,
    output logic [lsu_pkg::DATA_W-1:0] rsp_rdata,
    output logic                       rsp_err
);
    // Decode to execute and result
    logic                       dec_valid, dec_write, dec_misaligned, dec_unsigned;
    logic [lsu_pkg::ADDR_W-1:0] dec_addr;
    logic [lsu_pkg::DATA_W-1:0] dec_wdata;
    logic [3:0]                 dec_strb;
    logic [1:0]                 dec_offset;
    lsu_pkg::mem_size_t         dec_size;
    // Execute to result
    logic                       exe_done, exe_err, exe_write;
    logic [lsu_pkg::DATA_W-1:0] exe_rdata;
    // AXI-Lite between master and RAM
    logic [lsu_pkg::ADDR_W-1:0] awaddr, araddr;
    logic [lsu_pkg::DATA_W-1:0] wdata, rdata;
    logic [3:0]                 wstrb;
    logic [1:0]                 bresp, rresp;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;

    lsu_decode u_decode (
        .aclk, .rst_n, .req_valid, .req_write, .req_size, .req_unsigned,
        .req_addr, .req_wdata, .rsp_valid, .dec_valid, .dec_write, .dec_addr,
        .dec_wdata, .dec_strb, .dec_misaligned, .dec_offset, .dec_size,
        .dec_unsigned, .busy
    );

    lsu_axil_master u_master (
        .aclk, .rst_n, .dec_valid, .dec_write, .dec_addr, .dec_wdata, .dec_strb,
        .dec_misaligned, .exe_done, .exe_rdata, .exe_err, .exe_write,
        .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
        .bresp, .bvalid, .bready, .araddr, .arvalid, .arready,
        .rdata, .rresp, .rvalid, .rready
    );

    lsu_load_align u_align (
        .aclk, .rst_n, .exe_done, .exe_rdata, .exe_err, .exe_write,
        .dec_offset, .dec_size, .dec_unsigned, .rsp_valid, .rsp_rdata, .rsp_err
    );

    axil_bram u_bram (
        .aclk, .rst_n, .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid,
        .wready, .bresp, .bvalid, .bready, .araddr, .arvalid, .arready,
        .rdata, .rresp, .rvalid, .rready
    );

endmodule

/* run.sh */
#!/usr/bin/env bash
# Compile and run the load/store subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert --timescale 1ns/1ps \
        --top-module tb_lsu_subsystem -Mdir obj_dir -f build.f; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/Vtb_lsu_subsystem > sim.log 2>&1
sim_status=$?
cat sim.log

if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
if ! grep -q "Simulation passed" sim.log; then
    echo "Simulation ended without a result line"
    exit 1
fi
exit 0

/* tb_lsu_subsystem.sv */
// ==========================================================================
// Directed testbench for the load/store subsystem. Runs word, sub-word,
// misaligned and out-of-range accesses against a byte-level memory model.
// ==========================================================================
`timescale 1ns/1ps

module tb_lsu_subsystem;

    localparam int WAIT_LIMIT = 200;

    logic                       aclk;
    logic                       rst_n;
    logic                       req_valid;
    logic                       req_write;
    lsu_pkg::mem_size_t         req_size;
    logic                       req_unsigned;
    logic [lsu_pkg::ADDR_W-1:0] req_addr;
    logic [lsu_pkg::DATA_W-1:0] req_wdata;
    logic                       busy;
    logic                       rsp_valid;
    logic [lsu_pkg::DATA_W-1:0] rsp_rdata;
    logic                       rsp_err;

    // Reference memory with one entry per RAM word
    logic [lsu_pkg::DATA_W-1:0] ref_mem [lsu_pkg::MEM_WORDS];
    int                         value_errors;
    int                         timeout_errors;

    lsu_subsystem dut (
        .aclk, .rst_n, .req_valid, .req_write, .req_size, .req_unsigned,
        .req_addr, .req_wdata, .busy, .rsp_valid, .rsp_rdata, .rsp_err
    );

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    // Busy sampled on the falling edge
    task automatic wait_idle();
        int cycles;
        cycles = 0;
        @(negedge aclk);
        while (busy && cycles < WAIT_LIMIT) begin
            @(negedge aclk);
            cycles++;
        end
        if (busy) begin
            $display("Timeout: busy stayed high for %0d cycles", WAIT_LIMIT);
            timeout_errors++;
        end
    endtask

    // ======================================================================
    // One request against the memory model
    // ======================================================================
    task automatic do_access(input logic write, input lsu_pkg::mem_size_t size,
                             input logic uns, input logic [31:0] addr,
                             input logic [31:0] data);
        logic [31:0] exp_rdata;
        logic        exp_err;
        int unsigned word_idx;
        int          off;
        int          n;
        int          cycles;
        bit          done;
        word_idx = addr >> 2;
        off      = int'(addr[1:0]);
        case (size)
            lsu_pkg::SIZE_BYTE: n = 1;
            lsu_pkg::SIZE_HALF: n = 2;
            default:            n = 4;
        endcase
        exp_err = (size == lsu_pkg::SIZE_HALF && addr[0]) ||
                  (size == lsu_pkg::SIZE_WORD && addr[1:0] != 2'b00) ||
                  (word_idx >= lsu_pkg::MEM_WORDS);
        exp_rdata = '0;
        // Stores merge byte by byte and loads gather then extend
        if (!exp_err && write) begin
            for (int b = 0; b < n; b++) begin
                ref_mem[word_idx][8*(off+b) +: 8] = data[8*b +: 8];
            end
        end else if (!exp_err) begin
            for (int b = 0; b < n; b++) begin
                exp_rdata[8*b +: 8] = ref_mem[word_idx][8*(off+b) +: 8];
            end
            if (!uns && n < 4 && exp_rdata[8*n-1]) begin
                exp_rdata = exp_rdata | (32'hffff_ffff << (8*n));
            end
        end

        wait_idle();
        @(posedge aclk);
        req_valid    <= 1'b1;
        req_write    <= write;
        req_size     <= size;
        req_unsigned <= uns;
        req_addr     <= addr;
        req_wdata    <= data;
        @(posedge aclk);
        req_valid    <= 1'b0;

        // Busy rises the cycle after the strobe
        @(negedge aclk);
        assert (busy === 1'b1) else begin
            $display("[ERROR] busy: got 0x%h expected 0x1 (addr 0x%h)", busy, addr);
            value_errors++;
        end

        cycles = 0;
        done   = 1'b0;
        while (!done && cycles < WAIT_LIMIT) begin
            @(negedge aclk);
            done = rsp_valid;
            cycles++;
        end
        if (!done) begin
            $display("Timeout: no response for access at address 0x%h", addr);
            timeout_errors++;
        end else begin
            assert (rsp_rdata === exp_rdata) else begin
                $display("[ERROR] rsp_rdata: got 0x%h expected 0x%h (addr 0x%h)",
                         rsp_rdata, exp_rdata, addr);
                value_errors++;
            end
            assert (rsp_err === exp_err) else begin
                $display("[ERROR] rsp_err: got 0x%h expected 0x%h (addr 0x%h)",
                         rsp_err, exp_err, addr);
                value_errors++;
            end
            // Busy drops together with the response
            assert (busy === 1'b0) else begin
                $display("[ERROR] busy: got 0x%h expected 0x0 (addr 0x%h)", busy, addr);
                value_errors++;
            end
            // Response strobe is a single cycle
            @(negedge aclk);
            assert (rsp_valid === 1'b0) else begin
                $display("[ERROR] rsp_valid: got 0x%h expected 0x0 (addr 0x%h)",
                         rsp_valid, addr);
                value_errors++;
            end
        end
    endtask

    // ======================================================================
    // Tests
    // ======================================================================
    task automatic test_reset_state();
        @(negedge aclk);
        assert (busy === 1'b0) else begin
            $display("[ERROR] busy: got 0x%h expected 0x0", busy);
            value_errors++;
        end
        assert (rsp_valid === 1'b0) else begin
            $display("[ERROR] rsp_valid: got 0x%h expected 0x0", rsp_valid);
            value_errors++;
        end
        // First request after reset
        do_access(1'b1, lsu_pkg::SIZE_WORD, 1'b0, 32'h0000_000c, 32'h1234_5678);
        do_access(1'b0, lsu_pkg::SIZE_WORD, 1'b0, 32'h0000_000c, 32'h0);
    endtask

    // Known contents in every word from a pattern over the whole index
    task automatic fill_memory();
        for (int i = 0; i < lsu_pkg::MEM_WORDS; i++) begin
            do_access(1'b1, lsu_pkg::SIZE_WORD, 1'b0, i << 2, (i + 1) * 32'h9e37_79b9);
        end
    endtask

    task automatic test_word_round_trip();
        logic [31:0] addr;
        for (int i = 0; i < 24; i++) begin
            addr = $urandom_range(0, lsu_pkg::MEM_WORDS - 1) << 2;
            do_access(1'b1, lsu_pkg::SIZE_WORD, 1'b0, addr, $urandom);
            do_access(1'b0, lsu_pkg::SIZE_WORD, 1'b0, addr, 32'h0);
        end
    endtask

    task automatic test_sub_word_stores();
        logic [31:0] base;
        for (int i = 0; i < 16; i++) begin
            base = $urandom_range(0, lsu_pkg::MEM_WORDS - 1) << 2;
            do_access(1'b1, lsu_pkg::SIZE_BYTE, 1'b0, base | $urandom_range(0, 3), $urandom);
            do_access(1'b0, lsu_pkg::SIZE_WORD, 1'b0, base, 32'h0);
            do_access(1'b1, lsu_pkg::SIZE_HALF, 1'b0, base | ($urandom_range(0, 1) << 1),
                      $urandom);
            do_access(1'b0, lsu_pkg::SIZE_WORD, 1'b0, base, 32'h0);
        end
    endtask

    // Sign bit set and clear in every lane
    task automatic test_load_extension();
        logic [31:0] words [3];
        words[0] = 32'h80ff_7f01;
        words[1] = 32'h7fff_8000;
        words[2] = $urandom;
        for (int w = 0; w < 3; w++) begin
            do_access(1'b1, lsu_pkg::SIZE_WORD, 1'b0, (20 + w) << 2, words[w]);
            for (int off = 0; off < 4; off++) begin
                do_access(1'b0, lsu_pkg::SIZE_BYTE, 1'b0, ((20 + w) << 2) + off, 32'h0);
                do_access(1'b0, lsu_pkg::SIZE_BYTE, 1'b1, ((20 + w) << 2) + off, 32'h0);
            end
            for (int off = 0; off < 4; off += 2) begin
                do_access(1'b0, lsu_pkg::SIZE_HALF, 1'b0, ((20 + w) << 2) + off, 32'h0);
                do_access(1'b0, lsu_pkg::SIZE_HALF, 1'b1, ((20 + w) << 2) + off, 32'h0);
            end
        end
    endtask

    task automatic test_misaligned();
        do_access(1'b1, lsu_pkg::SIZE_HALF, 1'b0, 32'h0000_0029, 32'hdead_beef);
        do_access(1'b1, lsu_pkg::SIZE_HALF, 1'b0, 32'h0000_002b, 32'hdead_beef);
        for (int off = 1; off < 4; off++) begin
            do_access(1'b1, lsu_pkg::SIZE_WORD, 1'b0, 32'h0000_0028 + off, 32'hdead_beef);
            do_access(1'b0, lsu_pkg::SIZE_WORD, 1'b0, 32'h0000_0028 + off, 32'h0);
        end
        do_access(1'b0, lsu_pkg::SIZE_HALF, 1'b1, 32'h0000_0029, 32'h0);
        // Word must be untouched
        do_access(1'b0, lsu_pkg::SIZE_WORD, 1'b0, 32'h0000_0028, 32'h0);
    endtask

    task automatic test_out_of_range();
        logic [31:0] addrs [3];
        addrs[0] = lsu_pkg::MEM_WORDS << 2;
        addrs[1] = (lsu_pkg::MEM_WORDS + 1) << 2;
        addrs[2] = 32'hffff_fffc;
        for (int i = 0; i < 3; i++) begin
            do_access(1'b1, lsu_pkg::SIZE_WORD, 1'b0, addrs[i], 32'hbad0_bad0);
            do_access(1'b0, lsu_pkg::SIZE_WORD, 1'b0, addrs[i], 32'h0);
            do_access(1'b0, lsu_pkg::SIZE_BYTE, 1'b0, addrs[i] + 1, 32'h0);
        end
        // Aliased low words keep their contents
        do_access(1'b0, lsu_pkg::SIZE_WORD, 1'b0, 32'h0000_0000, 32'h0);
        do_access(1'b0, lsu_pkg::SIZE_WORD, 1'b0, 32'h0000_0004, 32'h0);
    endtask

    // ======================================================================
    // Sequence
    // ======================================================================
    initial begin
        value_errors   = 0;
        timeout_errors = 0;
        void'($urandom(32'hbeac_d887));
        rst_n          = 1'b0;
        req_valid      = 1'b0;
        req_write      = 1'b0;
        req_size       = lsu_pkg::SIZE_WORD;
        req_unsigned   = 1'b0;
        req_addr       = '0;
        req_wdata      = '0;
        repeat (10) @(posedge aclk);
        rst_n <= 1'b1;

        test_reset_state();
        fill_memory();
        test_word_round_trip();
        test_sub_word_stores();
        test_load_extension();
        test_misaligned();
        test_out_of_range();

        $display("Error count: %0d value mismatches, %0d timeouts",
                 value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
